//--- src.f
+incdir+testbench
verilog/tx_intf_pkg.sv
verilog/tx_fifo.sv
verilog/dma_burst_ctrl.sv
verilog/tx_queue_bank.sv
verilog/tx_intf_s_axis.sv
testbench/tb_tx_intf.sv

//--- run.sh
#!/bin/sh
# build and run the tx stream interface testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f src.f --top-module tb_tx_intf -o tb_tx_intf \
    && ./obj_dir/tb_tx_intf > sim.log 2>&1
status=$?

[ -f sim.log ] && cat sim.log

[ "$status" -eq 0 ] && [ -f sim.log ] && ! grep -q "tests failed" sim.log \
    && echo "simulation passed" \
    || { echo "simulation did not pass, see sim.log"; exit 1; }

exit 0

//--- testbench/tb_tx_intf_tasks.svh
// ************************************************************
// tx stream interface testbench: stimulus, checks and tests
// ************************************************************

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

task automatic next_word(output logic [DATA_W-1:0] w);
    rng_state = xorshift32(rng_state);
    w[63:32]  = rng_state;
    rng_state = xorshift32(rng_state);
    w[31:0]   = rng_state;
endtask

task automatic check_value(input string name, input logic [63:0] expected,
                           input logic [63:0] actual);
    check_count++;
    if (actual !== expected)
    begin
        $display("error %s %s: expected %h actual %h", test_name, name, expected, actual);
        error_count++;
    end
endtask

task automatic check_counts(input string what);
    check_value({what, " count0"}, 64'(sb[0].size()), 64'(data_count0));
    check_value({what, " count1"}, 64'(sb[1].size()), 64'(data_count1));
    check_value({what, " count2"}, 64'(sb[2].size()), 64'(data_count2));
    check_value({what, " count3"}, 64'(sb[3].size()), 64'(data_count3));
endtask

task automatic set_mode(input bit endless, input int symbols);
    @(posedge S_AXIS_ACLK);
    endless_mode   <= endless;
    num_dma_symbol <= SYMBOL_W'(symbols);
endtask

// offers up to n words, stops early once tready drops after a first accept
task automatic stream_burst(input int q, input int n, input bit with_last,
                            output int accepted);
    logic [DATA_W-1:0] word;
    int                idle_cycles;
    bit                stop;
    accepted    = 0;
    idle_cycles = 0;
    stop        = 1'b0;
    next_word(word);
    @(posedge S_AXIS_ACLK);
    tx_queue_idx_indication_from_ps <= QIDX_W'(q);
    s_axis_tvalid                   <= 1'b1;
    s_axis_tdata                    <= word;
    s_axis_tlast                    <= with_last && (n == 1);
    while (!stop)
    begin
        @(negedge S_AXIS_ACLK);
        if (s_axis_tready)
        begin
            sb[q].push_back(word);   // taken on the coming edge
            accepted++;
            next_word(word);
            @(posedge S_AXIS_ACLK);
            s_axis_tdata <= word;
            s_axis_tlast <= with_last && (accepted == n - 1);
            stop = (accepted == n);
        end
        else if (accepted > 0 || idle_cycles == BEAT_WAIT_LIMIT)
        begin
            if (accepted == 0)
            begin
                $display("%s: no beat accepted on queue %0d within %0d cycles",
                         test_name, q, BEAT_WAIT_LIMIT);
                error_count++;
            end
            @(posedge S_AXIS_ACLK);
            stop = 1'b1;
        end
        else
        begin
            idle_cycles++;
        end
    end
    s_axis_tvalid <= 1'b0;
    s_axis_tlast  <= 1'b0;
endtask

task automatic wait_idle();
    int cycles;
    cycles = 0;
    @(negedge S_AXIS_ACLK);
    while (recv_data_from_high && cycles < IDLE_WAIT_LIMIT)
    begin
        @(negedge S_AXIS_ACLK);
        cycles++;
    end
    if (recv_data_from_high)
    begin
        $display("%s: burst did not close within %0d cycles", test_name, IDLE_WAIT_LIMIT);
        error_count++;
    end
endtask

task automatic pop_and_check(input int q);
    @(posedge S_AXIS_ACLK);
    tx_queue_idx <= QIDX_W'(q);
    @(negedge S_AXIS_ACLK);
    if (!emptyn_to_acc || sb[q].size() == 0)
    begin
        $display("%s: queue %0d shows no word to read while %0d are expected",
                 test_name, q, sb[q].size());
        error_count++;
    end
    else
    begin
        check_value($sformatf("head of queue %0d", q), sb[q][0], data_to_acc);
        @(posedge S_AXIS_ACLK);
        acc_ask_data <= 1'b1;
        @(posedge S_AXIS_ACLK);
        acc_ask_data <= 1'b0;   // popped on this edge
        void'(sb[q].pop_front());
        @(negedge S_AXIS_ACLK);
        check_counts("after pop");
    end
endtask

task automatic drain_queue(input int q);
    int n;
    n = sb[q].size();
    repeat (n) pop_and_check(q);
    sb[q].delete();
    @(negedge S_AXIS_ACLK);
    check_value("emptyn after drain", 64'(0), 64'(emptyn_to_acc));
endtask

task automatic after_reset();
    test_name = "after_reset";
    @(negedge S_AXIS_ACLK);
    check_value("tready", 64'(0), 64'(s_axis_tready));
    check_value("emptyn", 64'(0), 64'(emptyn_to_acc));
    check_value("recv", 64'(0), 64'(recv_data_from_high));
    check_counts("after reset");
endtask

task automatic tlast_burst();
    int accepted;
    test_name = "tlast_burst";
    set_mode(1'b0, 1000);
    stream_burst(2, 5, 1'b1, accepted);
    check_value("accepted beats", 64'(5), 64'(accepted));
    wait_idle();
    check_counts("after burst");
    drain_queue(2);
endtask

task automatic symbol_limit();
    int accepted;
    test_name = "symbol_limit";
    set_mode(1'b0, 7);
    stream_burst(0, 20, 1'b0, accepted);
    check_value("accepted beats", 64'(8), 64'(accepted));
    wait_idle();
    repeat (4)
    begin
        @(negedge S_AXIS_ACLK);
        check_value("tready after limit", 64'(0), 64'(s_axis_tready));
    end
    check_value("data_count0", 64'(8), 64'(data_count0));
    drain_queue(0);
endtask

task automatic two_queue_isolation();
    int accepted;
    test_name = "two_queue_isolation";
    set_mode(1'b0, 1000);
    stream_burst(1, 6, 1'b1, accepted);
    check_value("accepted beats q1", 64'(6), 64'(accepted));
    wait_idle();
    stream_burst(3, 6, 1'b1, accepted);
    check_value("accepted beats q3", 64'(6), 64'(accepted));
    wait_idle();
    check_counts("after bursts");
    repeat (6)
    begin
        pop_and_check(1);   // pop_and_check also checks the other counts
        pop_and_check(3);
    end
endtask

task automatic endless_with_tlast();
    int accepted;
    test_name = "endless_with_tlast";
    set_mode(1'b1, 3);
    stream_burst(2, 20, 1'b1, accepted);
    check_value("accepted beats", 64'(20), 64'(accepted));
    wait_idle();
    check_counts("after burst");
    drain_queue(2);
endtask

task automatic full_queue_backpressure();
    int accepted;
    test_name = "full_queue_backpressure";
    set_mode(1'b1, 3);
    stream_burst(0, FIFO_DEPTH + 4, 1'b0, accepted);
    check_value("accepted until full", 64'(FIFO_DEPTH), 64'(accepted));
    repeat (3)
    begin
        @(negedge S_AXIS_ACLK);
        check_value("tready while full", 64'(0), 64'(s_axis_tready));
    end
    check_value("data_count0 when full", 64'(FIFO_DEPTH), 64'(data_count0));
    check_value("burst still open", 64'(1), 64'(recv_data_from_high));
    pop_and_check(0);
    stream_burst(0, 3, 1'b0, accepted);
    check_value("accepted after one pop", 64'(1), 64'(accepted));
    check_counts("refilled");
    drain_queue(0);
    stream_burst(0, 1, 1'b1, accepted);   // tlast closes the open burst
    check_value("closing beat", 64'(1), 64'(accepted));
    wait_idle();
    drain_queue(0);
endtask

//--- testbench/tb_tx_intf.sv
// ************************************************************
// testbench for the tx stream interface: directed bursts into
// the four queues, reads from the accelerator side
// ************************************************************

`timescale 1ns/1ps

module tb_tx_intf
    import tx_intf_pkg::*;
();

    localparam int CLK_PERIOD      = 4;
    localparam int RESET_CYCLES    = 10;
    localparam int BEAT_WAIT_LIMIT = 20;
    localparam int IDLE_WAIT_LIMIT = 10;
    localparam int TOTAL_BEATS     = 5 + 8 + 12 + 20 + FIFO_DEPTH + 2;
    localparam int TOTAL_POPS      = 5 + 8 + 12 + 20 + FIFO_DEPTH + 2;
    // a beat costs up to two cycles, a pop about four
    localparam int WATCHDOG_CYCLES =
        2 * (RESET_CYCLES + 2 * TOTAL_BEATS + 5 * TOTAL_POPS) + 200;

    logic                S_AXIS_ACLK;
    logic                S_AXIS_ARESETN;
    logic                s_axis_tvalid;
    logic                s_axis_tready;
    logic [DATA_W-1:0]   s_axis_tdata;
    logic [DATA_W/8-1:0] s_axis_tstrb;
    logic                s_axis_tlast;
    logic [QIDX_W-1:0]   tx_queue_idx_indication_from_ps;
    logic [QIDX_W-1:0]   tx_queue_idx;
    logic                endless_mode;
    logic [SYMBOL_W-1:0] num_dma_symbol;
    logic [DATA_W-1:0]   data_to_acc;
    logic                emptyn_to_acc;
    logic                acc_ask_data;
    logic [COUNT_W-1:0]  data_count0;
    logic [COUNT_W-1:0]  data_count1;
    logic [COUNT_W-1:0]  data_count2;
    logic [COUNT_W-1:0]  data_count3;
    logic                recv_data_from_high;

    logic [DATA_W-1:0] sb [NUM_QUEUES][$];   // expected words per queue
    logic [31:0]       rng_state = 32'h4439df78;
    string             test_name = "none";
    int                error_count = 0;
    int                check_count = 0;

    tx_intf_s_axis tx_intf_s_axis_i
    (
        .S_AXIS_ACLK                     (S_AXIS_ACLK),
        .S_AXIS_ARESETN                  (S_AXIS_ARESETN),
        .s_axis_tvalid                   (s_axis_tvalid),
        .s_axis_tready                   (s_axis_tready),
        .s_axis_tdata                    (s_axis_tdata),
        .s_axis_tstrb                    (s_axis_tstrb),
        .s_axis_tlast                    (s_axis_tlast),
        .tx_queue_idx_indication_from_ps (tx_queue_idx_indication_from_ps),
        .tx_queue_idx                    (tx_queue_idx),
        .endless_mode                    (endless_mode),
        .num_dma_symbol                  (num_dma_symbol),
        .data_to_acc                     (data_to_acc),
        .emptyn_to_acc                   (emptyn_to_acc),
        .acc_ask_data                    (acc_ask_data),
        .data_count0                     (data_count0),
        .data_count1                     (data_count1),
        .data_count2                     (data_count2),
        .data_count3                     (data_count3),
        .recv_data_from_high             (recv_data_from_high)
    );

    `include "tb_tx_intf_tasks.svh"

    always #(CLK_PERIOD / 2) S_AXIS_ACLK = ~S_AXIS_ACLK;

    initial
    begin
        S_AXIS_ACLK                      = 1'b0;
        S_AXIS_ARESETN                  <= 1'b0;
        s_axis_tvalid                   <= 1'b0;
        s_axis_tdata                    <= '0;
        s_axis_tstrb                    <= '1;   // strobes are ignored by the DUT
        s_axis_tlast                    <= 1'b0;
        tx_queue_idx_indication_from_ps <= '0;
        tx_queue_idx                    <= '0;
        endless_mode                    <= 1'b0;
        num_dma_symbol                  <= '0;
        acc_ask_data                    <= 1'b0;
        repeat (RESET_CYCLES) @(posedge S_AXIS_ACLK);
        S_AXIS_ARESETN <= 1'b1;

        after_reset();
        tlast_burst();
        symbol_limit();
        two_queue_isolation();
        endless_with_tlast();
        full_queue_backpressure();

        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0)
        begin
            $display("all tests passed");
        end
        else
        begin
            $display("tests failed");
        end
        $finish;
    end

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles in %s", WATCHDOG_CYCLES, test_name);
        $display("checks %0d, errors %0d", check_count, error_count + 1);
        $display("tests failed");
        $finish;
    end

endmodule

//--- verilog/tx_intf_s_axis.sv
// ***********************************************************
// tx stream interface top: AXI-Stream slave into four queues
// ***********************************************************

`timescale 1ns/1ps

module tx_intf_s_axis
    import tx_intf_pkg::*;
(
    input  logic                S_AXIS_ACLK,
    input  logic                S_AXIS_ARESETN,
    input  logic                s_axis_tvalid,
    output logic                s_axis_tready,
    input  logic [DATA_W-1:0]   s_axis_tdata,
    input  logic [DATA_W/8-1:0] s_axis_tstrb,
    input  logic                s_axis_tlast,
    input  logic [QIDX_W-1:0]   tx_queue_idx_indication_from_ps,
    input  logic [QIDX_W-1:0]   tx_queue_idx,
    input  logic                endless_mode,
    input  logic [SYMBOL_W-1:0] num_dma_symbol,
    output logic [DATA_W-1:0]   data_to_acc,
    output logic                emptyn_to_acc,
    input  logic                acc_ask_data,
    output logic [COUNT_W-1:0]  data_count0,
    output logic [COUNT_W-1:0]  data_count1,
    output logic [COUNT_W-1:0]  data_count2,
    output logic [COUNT_W-1:0]  data_count3,
    output logic                recv_data_from_high
);

    axis_beat_t    beat;
    queue_counts_t counts;
    logic          accept_window;
    logic          accept;

    assign beat = '{tdata: s_axis_tdata, tstrb: s_axis_tstrb, tlast: s_axis_tlast};

    assign data_count0 = counts.count0;
    assign data_count1 = counts.count1;
    assign data_count2 = counts.count2;
    assign data_count3 = counts.count3;

    dma_burst_ctrl dma_burst_ctrl_i
    (
        .S_AXIS_ACLK    (S_AXIS_ACLK),
        .S_AXIS_ARESETN (S_AXIS_ARESETN),
        .tvalid         (s_axis_tvalid),
        .beat_last      (beat.tlast),
        .accept         (accept),
        .num_dma_symbol (num_dma_symbol),
        .endless_mode   (endless_mode),
        .accept_window  (accept_window),
        .receiving      (recv_data_from_high)
    );

    tx_queue_bank tx_queue_bank_i
    (
        .S_AXIS_ACLK    (S_AXIS_ACLK),
        .S_AXIS_ARESETN (S_AXIS_ARESETN),
        .beat           (beat),
        .tvalid         (s_axis_tvalid),
        .accept_window  (accept_window),
        .wr_queue       (tx_queue_idx_indication_from_ps),
        .rd_queue       (tx_queue_idx),
        .ask_data       (acc_ask_data),
        .tready         (s_axis_tready),
        .accept         (accept),
        .data_out       (data_to_acc),
        .emptyn         (emptyn_to_acc),
        .counts         (counts)
    );

endmodule

//--- verilog/tx_queue_bank.sv
// ***********************************************************
// four transmit queues with write steering, ready gating
// and read-side selection for the accelerator
// ***********************************************************

`timescale 1ns/1ps

module tx_queue_bank
    import tx_intf_pkg::*;
(
    input  logic              S_AXIS_ACLK,
    input  logic              S_AXIS_ARESETN,
    input  axis_beat_t        beat,
    input  logic              tvalid,
    input  logic              accept_window,
    input  logic [QIDX_W-1:0] wr_queue,
    input  logic [QIDX_W-1:0] rd_queue,
    input  logic              ask_data,
    output logic              tready,
    output logic              accept,
    output logic [DATA_W-1:0] data_out,
    output logic              emptyn,
    output queue_counts_t     counts
);

    logic [NUM_QUEUES-1:0] wr_en;
    logic [NUM_QUEUES-1:0] rd_en;
    logic [NUM_QUEUES-1:0] empty;
    logic [NUM_QUEUES-1:0] full;
    logic [DATA_W-1:0]     head [NUM_QUEUES];
    logic [COUNT_W-1:0]    count [NUM_QUEUES];

    // ready only while the burst is open and the target queue has room
    assign tready = accept_window && !full[wr_queue];
    assign accept = tvalid && tready;

    assign data_out = head[rd_queue];
    assign emptyn   = !empty[rd_queue];

    genvar gi;
    generate
        for (gi = 0; gi < NUM_QUEUES; gi++)
        begin : g_queue
            assign wr_en[gi] = accept && (wr_queue == QIDX_W'(gi));
            assign rd_en[gi] = ask_data && (rd_queue == QIDX_W'(gi));

            tx_fifo tx_fifo_i
            (
                .S_AXIS_ACLK    (S_AXIS_ACLK),
                .S_AXIS_ARESETN (S_AXIS_ARESETN),
                .wr_en          (wr_en[gi]),
                .wr_data        (beat.tdata),
                .rd_en          (rd_en[gi]),
                .rd_data        (head[gi]),
                .empty          (empty[gi]),
                .full           (full[gi]),
                .data_count     (count[gi])
            );
        end
    endgenerate

    assign counts.count0 = count[0];
    assign counts.count1 = count[1];
    assign counts.count2 = count[2];
    assign counts.count3 = count[3];

    // write queue is taken combinationally, software keeps it fixed within a burst
    a_wr_queue_stable: assert property (
        @(posedge S_AXIS_ACLK) disable iff (!S_AXIS_ARESETN)
        (accept_window && $past(accept_window)) |-> $stable(wr_queue)
    ) else $error("tx_queue_bank: write queue changed during burst");

endmodule

//--- verilog/dma_burst_ctrl.sv
// ***********************************************************
// burst controller: symbol pointer, end-of-burst detection
// and the window in which stream beats may be accepted
// ***********************************************************

`timescale 1ns/1ps

module dma_burst_ctrl
    import tx_intf_pkg::*;
(
    input  logic                S_AXIS_ACLK,
    input  logic                S_AXIS_ARESETN,
    input  logic                tvalid,
    input  logic                beat_last,
    input  logic                accept,
    input  logic [SYMBOL_W-1:0] num_dma_symbol,
    input  logic                endless_mode,
    output logic                accept_window,
    output logic                receiving
);

    burst_state_t        state;
    logic [SYMBOL_W-1:0] write_pointer;
    logic                writes_done;
    logic                within_limit;
    logic                at_limit;

    // num_dma_symbol counts from zero, so limit+1 beats fit
    assign within_limit = (write_pointer <= num_dma_symbol) || endless_mode;
    assign at_limit     = (write_pointer == num_dma_symbol) && !endless_mode;

    assign accept_window = (state == WRITE_FIFO) && !writes_done && within_limit;
    assign receiving     = (state == WRITE_FIFO);

    always_ff @(posedge S_AXIS_ACLK)
    begin
        if (!S_AXIS_ARESETN)
        begin
            state <= IDLE;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (tvalid)
                    begin
                        state <= WRITE_FIFO;   // first beat taken next cycle
                    end
                end
                WRITE_FIFO:
                begin
                    if (writes_done)
                    begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge S_AXIS_ACLK)
    begin
        if (!S_AXIS_ARESETN || writes_done)
        begin
            write_pointer <= '0;
            writes_done   <= 1'b0;
        end
        else if (accept)
        begin
            write_pointer <= write_pointer + 1'b1;
            if (at_limit || beat_last)
            begin
                writes_done <= 1'b1;   // tready low for one cycle, then idle
            end
        end
    end

    // limited bursts stop at num_dma_symbol+1 beats, pointer cannot run past it
    a_pointer_limit: assert property (
        @(posedge S_AXIS_ACLK) disable iff (!S_AXIS_ARESETN)
        !endless_mode |-> ({1'b0, write_pointer} <= {1'b0, num_dma_symbol} + 1'b1)
    ) else $error("dma_burst_ctrl: pointer beyond symbol limit");

endmodule

//--- verilog/tx_fifo.sv
// ***********************************************************
// single-clock first-word-fall-through queue with fill count
// ***********************************************************

`timescale 1ns/1ps

module tx_fifo
    import tx_intf_pkg::*;
(
    input  logic               S_AXIS_ACLK,
    input  logic               S_AXIS_ARESETN,
    input  logic               wr_en,
    input  logic [DATA_W-1:0]  wr_data,
    input  logic               rd_en,
    output logic [DATA_W-1:0]  rd_data,
    output logic               empty,
    output logic               full,
    output logic [COUNT_W-1:0] data_count
);

    logic [DATA_W-1:0]  mem [FIFO_DEPTH];
    logic [ADDR_W-1:0]  wr_ptr;
    logic [ADDR_W-1:0]  rd_ptr;
    logic [COUNT_W-1:0] count;
    logic               wr_ok;
    logic               rd_ok;

    assign wr_ok = wr_en && !full;
    assign rd_ok = rd_en && !empty;   // pop of empty queue is dropped

    assign empty      = (count == '0);
    assign full       = (count == COUNT_W'(FIFO_DEPTH));
    assign data_count = count;
    assign rd_data    = mem[rd_ptr];  // head word, no read latency

    always_ff @(posedge S_AXIS_ACLK)
    begin
        if (wr_ok)
        begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge S_AXIS_ACLK)
    begin
        if (!S_AXIS_ARESETN)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (wr_ok)
            begin
                wr_ptr <= wr_ptr + 1'b1;   // wraps, depth is a power of two
            end
            if (rd_ok)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // idle or write and pop together
            endcase
        end
    end

    // the bank gates tready with full, so no write should ever reach a full queue
    a_no_write_full: assert property (
        @(posedge S_AXIS_ACLK) disable iff (!S_AXIS_ARESETN)
        wr_en |-> !full
    ) else $error("tx_fifo: write while full");

    // accelerator must only pop while emptyn is shown
    a_no_pop_empty: assert property (
        @(posedge S_AXIS_ACLK) disable iff (!S_AXIS_ARESETN)
        rd_en |-> !empty
    ) else $error("tx_fifo: pop while empty");

endmodule

//--- verilog/tx_intf_pkg.sv
// ***********************************************************
// tx stream interface package: widths, queue depth and the
// burst state and beat/count types shared by the design
// ***********************************************************

package tx_intf_pkg;

    localparam int DATA_W     = 64;
    localparam int NUM_QUEUES = 4;
    localparam int QIDX_W     = 2;
    localparam int FIFO_DEPTH = 64;                  // small so full is reachable in sim
    localparam int ADDR_W     = $clog2(FIFO_DEPTH);
    localparam int COUNT_W    = 7;                   // 0 .. FIFO_DEPTH
    localparam int SYMBOL_W   = 14;

    typedef enum logic [0:0]
    {
        IDLE       = 1'b0,
        WRITE_FIFO = 1'b1
    } burst_state_t;

    // one stream beat as seen on the slave port
    typedef struct packed
    {
        logic [DATA_W-1:0]   tdata;
        logic [DATA_W/8-1:0] tstrb;   // carried, not used
        logic                tlast;
    } axis_beat_t;

    // fill level of each transmit queue
    typedef struct packed
    {
        logic [COUNT_W-1:0] count0;
        logic [COUNT_W-1:0] count1;
        logic [COUNT_W-1:0] count2;
        logic [COUNT_W-1:0] count3;
    } queue_counts_t;

endpackage
